/* run_sim.sh */
#!/bin/sh
# Build and run the sprite line engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module sprite_line_engine_tb -f sprite_line_engine.f -o sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Simulation finished: PASS$"; then
	exit 0
fi
exit 1

/* sprite_line_engine.f */
src/sprite_pkg.sv
src/sprite_table_scanner.sv
src/sprite_pixel_fetch.sv
src/sprite_line_buffer.sv
src/sprite_line_engine.sv
test/sprite_line_engine_tb.sv

/* src/sprite_line_buffer.sv */
`default_nettype none

module sprite_line_buffer (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             line_start,
	input  wire sprite_pkg::lb_write_t      lb_wr,
	input  wire  [sprite_pkg::POS_W-1:0]    hcnt,
	output logic                            clearing,
	output logic [7:0]                      spr_r,
	output logic [7:0]                      spr_g,
	output logic [7:0]                      spr_b,
	output logic                            spr_a
);

	localparam int PW = sprite_pkg::POS_W;

	// Two slots of 512 words selected by the top address bit
	sprite_pkg::colour_t mem [0:(2 << PW) - 1];

	logic                wr_slot;
	logic [PW-1:0]       clr_addr;
	logic [PW-1:0]       rd_addr;
	logic [PW:0]         wa;
	sprite_pkg::colour_t wd;
	logic                we;
	sprite_pkg::colour_t rd_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_slot <= 1'b0;
			clearing <= 1'b0;
			clr_addr <= '0;
		end
		else if (line_start)
		begin
			wr_slot <= ~wr_slot;
			clearing <= 1'b1;
			clr_addr <= '0;
		end
		else if (clearing)
		begin
			clr_addr <= clr_addr + 1'b1;
			if (clr_addr == sprite_pkg::LINE_MAX)
				clearing <= 1'b0;
		end
	end

	// The sweep owns the write port while it runs
	always_comb
	begin
		if (clearing)
		begin
			wa = {wr_slot, clr_addr};
			wd = '0;
			we = 1'b1;
		end
		else
		begin
			wa = {wr_slot, lb_wr.addr};
			wd = lb_wr.data;
			we = lb_wr.en;
		end
	end

	assign rd_addr = hcnt + sprite_pkg::BORDER;

	always_ff @(posedge clk)
	begin
		if (we)
			mem[wa] <= wd;
		rd_q <= mem[{~wr_slot, rd_addr}];
	end

	// 5 to 8 bit expansion repeats the top bits
	assign spr_r = {rd_q.red, rd_q.red[4:2]};
	assign spr_g = {rd_q.green, rd_q.green[4:2]};
	assign spr_b = {rd_q.blue, rd_q.blue[4:2]};
	assign spr_a = rd_q.alpha;

	no_write_in_clear: assert property (@(posedge clk) disable iff (reset)
		lb_wr.en |-> !clearing);

endmodule

`default_nettype wire

/* src/sprite_line_engine.sv */
`default_nettype none

module sprite_line_engine #(
	parameter int          SPRITE_COUNT = 32,
	parameter int          IMG_W        = 14,
	parameter int unsigned BASE_32      = 0,
	parameter int unsigned BASE_16      = 8192,
	parameter int unsigned BASE_8       = 12288
) (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          hsync,
	input  wire  [sprite_pkg::POS_W-1:0] vcnt,
	input  wire  [sprite_pkg::POS_W-1:0] hcnt,
	output logic [6:0]                   spr_ram_addr,
	input  wire  [7:0]                   spr_ram_data,
	output logic [IMG_W-1:0]             img_addr,
	input  wire  [7:0]                   img_data,
	output logic [6:0]                   pal_addr,
	input  wire sprite_pkg::colour_t     pal_data,
	output logic [7:0]                   spr_r,
	output logic [7:0]                   spr_g,
	output logic [7:0]                   spr_b,
	output logic                         spr_a,
	output logic                         busy
);

	logic                    hsync_q;
	logic                    line_start;
	logic                    clearing;
	sprite_pkg::sprite_job_t job;
	logic                    job_req;
	logic                    job_ack;
	sprite_pkg::lb_write_t   lb_wr;

	// One cycle pulse on each rising hsync
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hsync_q <= 1'b0;
			line_start <= 1'b0;
		end
		else
		begin
			hsync_q <= hsync;
			line_start <= hsync && !hsync_q;
		end
	end

	sprite_table_scanner #(
		.SPRITE_COUNT(SPRITE_COUNT)
	) u_scanner (
		.clk(clk),
		.reset(reset),
		.line_start(line_start),
		.vcnt(vcnt),
		.clearing(clearing),
		.spr_ram_addr(spr_ram_addr),
		.spr_ram_data(spr_ram_data),
		.job(job),
		.job_req(job_req),
		.job_ack(job_ack),
		.busy(busy)
	);

	sprite_pixel_fetch #(
		.IMG_W(IMG_W),
		.BASE_32(BASE_32),
		.BASE_16(BASE_16),
		.BASE_8(BASE_8)
	) u_fetch (
		.clk(clk),
		.reset(reset),
		.job(job),
		.job_req(job_req),
		.job_ack(job_ack),
		.img_addr(img_addr),
		.img_data(img_data),
		.pal_addr(pal_addr),
		.pal_data(pal_data),
		.lb_wr(lb_wr)
	);

	sprite_line_buffer u_line_buffer (
		.clk(clk),
		.reset(reset),
		.line_start(line_start),
		.lb_wr(lb_wr),
		.hcnt(hcnt),
		.clearing(clearing),
		.spr_r(spr_r),
		.spr_g(spr_g),
		.spr_b(spr_b),
		.spr_a(spr_a)
	);

	// A new line must not swap slots under a running scan
	no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
		line_start |-> !busy);

endmodule

`default_nettype wire

/* src/sprite_pixel_fetch.sv */
`default_nettype none

module sprite_pixel_fetch #(
	parameter int          IMG_W   = 14,
	parameter int unsigned BASE_32 = 0,
	parameter int unsigned BASE_16 = 8192,
	parameter int unsigned BASE_8  = 12288
) (
	input  wire                          clk,
	input  wire                          reset,
	input  wire sprite_pkg::sprite_job_t job,
	input  wire                          job_req,
	output logic                         job_ack,
	output logic [IMG_W-1:0]             img_addr,
	input  wire  [7:0]                   img_data,
	output logic [6:0]                   pal_addr,
	input  wire sprite_pkg::colour_t     pal_data,
	output sprite_pkg::lb_write_t        lb_wr
);

	localparam int PW = sprite_pkg::POS_W;

	typedef enum logic [2:0] {F_IDLE, F_RUN, F_LAST, F_ACK, F_HOLD} state_e;

	state_e           state;
	logic             job_req_q;
	logic [1:0]       ph;
	logic [4:0]       n;
	logic             pend;
	logic [PW-1:0]    wr_x;
	logic [PW-1:0]    side;
	logic [PW-1:0]    last_px;
	logic [IMG_W-1:0] base;
	logic [IMG_W-1:0] img_off;
	logic [IMG_W-1:0] row_off;
	logic [IMG_W-1:0] start_addr;
	logic             pix_wr;

	assign side = sprite_pkg::side_of(job.size);
	assign last_px = side - 1'b1;

	// Row start in the image ROM
	always_comb
	begin
		case (job.size)
			sprite_pkg::SIZE_32:
			begin
				base = IMG_W'(BASE_32);
				img_off = IMG_W'({job.image, 10'd0});
				row_off = IMG_W'({job.row, 5'd0});
			end
			sprite_pkg::SIZE_16:
			begin
				base = IMG_W'(BASE_16);
				img_off = IMG_W'({job.image, 8'd0});
				row_off = IMG_W'({job.row, 4'd0});
			end
			default:
			begin
				base = IMG_W'(BASE_8);
				img_off = IMG_W'({job.image, 6'd0});
				row_off = IMG_W'({job.row, 3'd0});
			end
		endcase
		start_addr = base + img_off + row_off;
		if (job.mirror)
			start_addr = start_addr + IMG_W'(last_px);
	end

	// Palette data of the previous pixel is valid here
	assign pix_wr = (state == F_RUN && ph == 2'd0 && pend) || state == F_LAST;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= F_IDLE;
			job_req_q <= 1'b0;
			job_ack <= 1'b0;
			lb_wr.en <= 1'b0;
			ph <= '0;
			n <= '0;
			pend <= 1'b0;
		end
		else
		begin
			job_req_q <= job_req;
			lb_wr.en <= pix_wr && pal_data.alpha;
			lb_wr.addr <= wr_x;
			lb_wr.data <= pal_data;
			case (state)
				F_IDLE:
				begin
					if (job_req && !job_req_q)
					begin
						img_addr <= start_addr;
						n <= '0;
						ph <= '0;
						pend <= 1'b0;
						state <= F_RUN;
					end
				end
				F_RUN:
				begin
					case (ph)
						2'd0: ph <= 2'd1;
						2'd1:
						begin
							pal_addr <= {job.palette, img_data[4:0]};
							wr_x <= job.x + PW'(n);
							pend <= 1'b1;
							img_addr <= job.mirror ? img_addr - 1'b1 : img_addr + 1'b1;
							ph <= 2'd2;
						end
						default:
						begin
							ph <= 2'd0;
							if (n == last_px[4:0])
								state <= F_LAST;
							else
								n <= n + 5'd1;
						end
					endcase
				end
				F_LAST: state <= F_ACK;
				F_ACK:
				begin
					job_ack <= 1'b1;
					state <= F_HOLD;
				end
				default:
				begin
					if (!job_req)
					begin
						job_ack <= 1'b0;
						state <= F_IDLE;
					end
				end
			endcase
		end
	end

	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(job_ack) |-> job_req);

endmodule

`default_nettype wire

/* src/sprite_pkg.sv */
`default_nettype none

package sprite_pkg;

	localparam int POS_W = 9;

	// Hidden border left of and above the visible area
	localparam logic [POS_W-1:0] BORDER = 9'd32;
	localparam logic [POS_W-1:0] LINE_MAX = 9'd352;

	typedef enum logic [1:0] {
		SIZE_32  = 2'd0,
		SIZE_16  = 2'd1,
		SIZE_8   = 2'd2,
		SIZE_OFF = 2'd3
	} size_code_e;

	typedef struct packed {
		logic             enable;
		logic [1:0]       palette;
		size_code_e       size;
		logic             mirror;
		logic [POS_W-1:0] y;
		logic [6:0]       image;
		logic [POS_W-1:0] x;
	} sprite_attr_t;

	typedef struct packed {
		logic [POS_W-1:0] x;
		size_code_e       size;
		logic [4:0]       row;
		logic [6:0]       image;
		logic [1:0]       palette;
		logic             mirror;
	} sprite_job_t;

	// Blue in the high channel, red in the low one
	typedef struct packed {
		logic       alpha;
		logic [4:0] blue;
		logic [4:0] green;
		logic [4:0] red;
	} colour_t;

	typedef struct packed {
		logic             en;
		logic [POS_W-1:0] addr;
		colour_t          data;
	} lb_write_t;

	// Edge length in pixels or zero for a disabled size
	function automatic logic [POS_W-1:0] side_of(size_code_e size);
		case (size)
			SIZE_32: return POS_W'(32);
			SIZE_16: return POS_W'(16);
			SIZE_8:  return POS_W'(8);
			default: return '0;
		endcase
	endfunction

endpackage

`default_nettype wire

/* src/sprite_table_scanner.sv */
`default_nettype none

module sprite_table_scanner #(
	parameter int SPRITE_COUNT = 32
) (
	input  wire                               clk,
	input  wire                               reset,
	input  wire                               line_start,
	input  wire  [sprite_pkg::POS_W-1:0]      vcnt,
	input  wire                               clearing,
	output logic [6:0]                        spr_ram_addr,
	input  wire  [7:0]                        spr_ram_data,
	output sprite_pkg::sprite_job_t           job,
	output logic                              job_req,
	input  wire                               job_ack,
	output logic                              busy
);

	localparam int IDX_W = $clog2(SPRITE_COUNT);
	localparam int PW = sprite_pkg::POS_W;

	typedef enum logic [2:0] {S_IDLE, S_CLEAR, S_READ, S_REQ, S_RELEASE} state_e;

	state_e                   state;
	logic [IDX_W-1:0]         idx;
	logic [2:0]               phase;
	logic                     clearing_q;
	logic [PW-1:0]            active_y;
	logic [PW-1:0]            dy;
	logic [PW-1:0]            side;
	sprite_pkg::sprite_attr_t attr;
	logic                     visible;
	logic [4:0]               row;
	logic                     last_rec;
	logic                     advance;

	// Byte within the record follows the low phase bits
	assign spr_ram_addr = 7'({idx, phase[1:0]});
	assign busy = (state != S_IDLE);

	assign side = sprite_pkg::side_of(attr.size);
	assign dy = active_y - attr.y;
	assign last_rec = (idx == IDX_W'(SPRITE_COUNT - 1));
	assign advance = (state == S_READ && phase == 3'd7 && !visible) ||
		(state == S_RELEASE && !job_ack);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			idx <= '0;
			phase <= '0;
			clearing_q <= 1'b0;
			visible <= 1'b0;
			job_req <= 1'b0;
		end
		else
		begin
			clearing_q <= clearing;
			case (state)
				S_IDLE:
				begin
					if (line_start)
					begin
						active_y <= vcnt + sprite_pkg::BORDER + 9'd1;
						state <= S_CLEAR;
					end
				end
				S_CLEAR:
				begin
					// Start the table once the sweep has finished
					if (clearing_q && !clearing)
					begin
						idx <= '0;
						phase <= '0;
						state <= S_READ;
					end
				end
				S_READ:
				begin
					phase <= phase + 3'd1;
					case (phase)
						3'd1:
						begin
							attr.enable <= spr_ram_data[7];
							attr.palette <= spr_ram_data[5:4];
							attr.size <= sprite_pkg::size_code_e'(spr_ram_data[3:2]);
							attr.mirror <= spr_ram_data[1];
							attr.y[8] <= spr_ram_data[0];
						end
						3'd2: attr.y[7:0] <= spr_ram_data;
						3'd3:
						begin
							attr.image <= spr_ram_data[7:1];
							attr.x[8] <= spr_ram_data[0];
						end
						3'd4: attr.x[7:0] <= spr_ram_data;
						3'd5:
						begin
							visible <= attr.enable && attr.size != sprite_pkg::SIZE_OFF &&
								active_y >= attr.y && dy < side;
							row <= dy[4:0];
						end
						3'd6:
						begin
							job.x <= attr.x;
							job.size <= attr.size;
							job.row <= row;
							job.image <= attr.image;
							job.palette <= attr.palette;
							job.mirror <= attr.mirror;
						end
						3'd7:
						begin
							if (visible)
							begin
								job_req <= 1'b1;
								state <= S_REQ;
							end
						end
						default: ;
					endcase
				end
				S_REQ:
				begin
					if (job_ack)
					begin
						job_req <= 1'b0;
						state <= S_RELEASE;
					end
				end
				// S_RELEASE leaves through the advance logic below
				default: ;
			endcase

			if (advance)
			begin
				if (last_rec)
					state <= S_IDLE;
				else
				begin
					idx <= idx + 1'b1;
					phase <= '0;
					state <= S_READ;
				end
			end
		end
	end

	// The fetcher relies on a steady job for the whole row
	job_stable: assert property (@(posedge clk) disable iff (reset)
		job_req |=> !job_req || $stable(job));

endmodule

`default_nettype wire

/* test/sprite_line_engine_tb.sv */
`default_nettype none

module sprite_line_engine_tb;

	localparam int SPRITE_COUNT = 32;
	localparam int IMG_W = 14;
	localparam int BASE_32 = 0;
	localparam int BASE_16 = 8192;
	localparam int BASE_8 = 12288;
	localparam int BORDER = 32;
	localparam int CYCLES_PER_LINE = 20000;

	logic             clk;
	logic             reset;
	logic             hsync;
	logic [8:0]       vcnt;
	logic [8:0]       hcnt;
	logic [6:0]       spr_ram_addr;
	logic [7:0]       spr_ram_data = '0;
	logic [IMG_W-1:0] img_addr;
	logic [7:0]       img_data = '0;
	logic [6:0]       pal_addr;
	logic [15:0]      pal_data = '0;
	logic [7:0]       spr_r;
	logic [7:0]       spr_g;
	logic [7:0]       spr_b;
	logic             spr_a;
	logic             busy;

	// Model contents that the reference line builder also reads
	logic [7:0]  spr_mem [0:127];
	logic [15:0] pal_mem [0:127];
	logic [7:0]  img_mem [0:(1 << IMG_W) - 1];
	logic [15:0] stim [0:383];
	logic [15:0] ref_line [0:511];
	int          n_lines = 0;
	logic [7:0]  spr_next;
	logic [7:0]  img_next;
	logic [15:0] pal_next;

	sprite_line_engine #(
		.SPRITE_COUNT(SPRITE_COUNT),
		.IMG_W(IMG_W),
		.BASE_32(BASE_32),
		.BASE_16(BASE_16),
		.BASE_8(BASE_8)
	) dut (
		.clk(clk),
		.reset(reset),
		.hsync(hsync),
		.vcnt(vcnt),
		.hcnt(hcnt),
		.spr_ram_addr(spr_ram_addr),
		.spr_ram_data(spr_ram_data),
		.img_addr(img_addr),
		.img_data(img_data),
		.pal_addr(pal_addr),
		.pal_data(pal_data),
		.spr_r(spr_r),
		.spr_g(spr_g),
		.spr_b(spr_b),
		.spr_a(spr_a),
		.busy(busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Synchronous memories return data a little after the edge that takes the address
	always @(posedge clk)
	begin
		spr_next = spr_mem[spr_ram_addr];
		img_next = img_mem[img_addr];
		pal_next = pal_mem[pal_addr];
		#2;
		spr_ram_data = spr_next;
		img_data = img_next;
		pal_data = pal_next;
	end

	task automatic stop_run;
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [7:0] got,
		input logic [7:0] want, input int h);
		assert (got == want)
		else
		begin
			$display("FAILED %s at vcnt %0d hcnt %0d: got %h, expected %h",
				name, vcnt, h, got, want);
			stop_run();
		end
	endtask

	function automatic logic [7:0] expand_channel(input logic [4:0] c);
		return {c, c[4:2]};
	endfunction

	// Expected write slot content for one line with sprites drawn in table order
	task automatic build_reference(input int line);
		int         i;
		int         s;
		int         act;
		int         side;
		int         base;
		int         y;
		int         x;
		int         addr;
		int         p;
		int         pidx;
		logic [7:0] b0;
		logic [15:0] col;
		for (i = 0; i < 512; i++)
			ref_line[i] = '0;
		act = (line + BORDER + 1) % 512;
		for (s = 0; s < SPRITE_COUNT; s++)
		begin
			b0 = spr_mem[4 * s];
			y = {b0[0], spr_mem[4 * s + 1]};
			x = {spr_mem[4 * s + 2][0], spr_mem[4 * s + 3]};
			case (b0[3:2])
				2'd0:
				begin
					side = 32;
					base = BASE_32;
				end
				2'd1:
				begin
					side = 16;
					base = BASE_16;
				end
				2'd2:
				begin
					side = 8;
					base = BASE_8;
				end
				default:
				begin
					side = 0;
					base = 0;
				end
			endcase
			if (b0[7] && side != 0 && act >= y && act <= y + side - 1)
			begin
				addr = base + spr_mem[4 * s + 2][7:1] * side * side + (act - y) * side;
				if (b0[1])
					addr = addr + side - 1;
				for (p = 0; p < side; p++)
				begin
					pidx = b0[5:4] * 32 + img_mem[(b0[1] ? addr - p : addr + p) & 16'h3fff][4:0];
					col = pal_mem[pidx];
					if (col[15])
						ref_line[(x + p) % 512] = col;
				end
			end
		end
	endtask

	task automatic pulse_hsync;
		@(posedge clk);
		#2 hsync = 1'b1;
		@(posedge clk);
		#2 hsync = 1'b0;
		@(posedge clk);
		#2;
		assert (busy)
		else
		begin
			$display("ERROR: busy did not rise after the line start");
			stop_run();
		end
	endtask

	task automatic wait_idle;
		while (busy)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	// Read data follows hcnt by one cycle
	task automatic check_line;
		int          h;
		logic [15:0] want;
		for (h = 0; h < 320; h++)
		begin
			@(posedge clk);
			#2 hcnt = 9'(h);
			@(posedge clk);
			#2;
			want = ref_line[(h + BORDER) % 512];
			check_value("spr_a", {7'd0, spr_a}, {7'd0, want[15]}, h);
			check_value("spr_r", spr_r, expand_channel(want[4:0]), h);
			check_value("spr_g", spr_g, expand_channel(want[9:5]), h);
			check_value("spr_b", spr_b, expand_channel(want[14:10]), h);
		end
	endtask

	initial
	begin
		int i;
		reset = 1'b1;
		hsync = 1'b0;
		vcnt = '0;
		hcnt = '0;
		void'($urandom(1861));
		for (i = 0; i < 384; i++)
			stim[i] = '0;
		$readmemh("test/sprite_line_input.txt", stim);
		for (i = 0; i < 128; i++)
		begin
			spr_mem[i] = stim[i][7:0];
			pal_mem[i] = stim[128 + i];
		end
		for (i = 0; i < (1 << IMG_W); i++)
			img_mem[i] = 8'($urandom);
		n_lines = int'(stim[256]);
		assert (n_lines > 0 && n_lines <= 127)
		else
		begin
			$display("ERROR: the input file gives no usable count of lines to render");
			stop_run();
		end

		repeat (5) @(posedge clk);
		#2 reset = 1'b0;
		@(posedge clk);
		#2;
		assert (!busy)
		else
		begin
			$display("ERROR: busy is high after reset");
			stop_run();
		end

		for (i = 0; i < n_lines; i++)
		begin
			vcnt = stim[257 + i][8:0];
			build_reference(int'(vcnt));
			pulse_hsync();
			wait_idle();
			// Second start swaps the rendered slot onto the read side
			pulse_hsync();
			check_line();
			wait_idle();
		end

		$display("Simulation finished: PASS");
		$finish;
	end

	initial
	begin
		wait (n_lines > 0);
		repeat (n_lines * CYCLES_PER_LINE + 20) @(posedge clk);
		$display("ERROR: timeout, the lines were not rendered within %0d cycles",
			n_lines * CYCLES_PER_LINE + 20);
		stop_run();
	end

endmodule

`default_nettype wire

/* test/sprite_line_input.txt */
// Sprite RAM at 000, four bytes per record: control, Y low, image and X high, X low
// Palette words at 080 (alpha in bit 15), line count at 100, vcnt of each line after it
@000 80 28 04 3C
@004 96 32 0A 46
@008 88 3C 13 2C
// Size code 3 and a disabled record, neither may draw
@00C 9C 28 02 64
@010 04 28 06 78
@014 9A 2C 28 4C
@018 87 04 06 14
// Last record of the table, partly beyond the right edge
@07C 90 46 0D 4A
// Palette 0 then palette 1, 32 words each
@080
8000 0421 7C1F 83E0 FC00 0A5A 9CE7 B5AD 0000 C631 8842 E739 10F0 F7BD 8C63 A94A
D294 0318 FFFF 8A51 6B5A 9F00 80FF 0C0C BDEF 84B2 F0F0 2222 AC63 91C8 7FFF E01F
83FF 0F0F C210 A0A0 5555 FA50 8125 E6D3 3C3C 99AA B0C0 0101 D7E8 8F1E 4040 C864
9A2B 0BEE F00D 8765 ABC1 1234 D3A1 B6E4 7777 C9F2 8421 0FED F4C2 0BAD 9999 E5E5
// Lines to render
@100 000D
0000 0007 000B 0011 001A 001B 0022 0026 0027 0041 00E3 00F2 00F3
